//--- logic/adc5g_pkg.sv
// ======================================
// shared constants and the config word
// type for the dual ADC serial controller
// import it inside each module body
// ======================================
package adc5g_pkg;

  localparam int num_adc = 2;

  // register map, word index taken from paddr[3:2]
  localparam int reg_ctrl_idx = 0;
  localparam int reg_cfg_base = 1;  // channel n at base + n

  localparam int bus_width      = 32;
  localparam int cfg_addr_width = 8;
  localparam int cfg_data_width = 16;
  localparam int frame_bits     = 24;
  localparam int prog_bits      = $clog2(frame_bits + 1);
  localparam int cfg_write_bit  = 7;  // set means write

  // 32 bus cycles per serial bit
  localparam int sclk_div_bits    = 5;
  localparam int sclk_fall_cnt    = 0;   // sdata changes
  localparam int sclk_prerise_cnt = 15;  // sdout sampled
  localparam int sclk_midhigh_cnt = 24;  // end of frame test

  localparam int rst_cycles   = 16;
  localparam int rst_cnt_bits = $clog2(rst_cycles + 1);

  localparam int state_bits = 3;
  localparam logic [state_bits-1:0] st_idle        = 3'd0;
  localparam logic [state_bits-1:0] st_clkwait     = 3'd1;
  localparam logic [state_bits-1:0] st_addr        = 3'd2;
  localparam logic [state_bits-1:0] st_readwait    = 3'd3;
  localparam logic [state_bits-1:0] st_write       = 3'd4;
  localparam logic [state_bits-1:0] st_read        = 3'd5;
  localparam logic [state_bits-1:0] st_almost_done = 3'd6;
  localparam logic [state_bits-1:0] st_finish      = 3'd7;

  // same word seen as command on write, status on read
  typedef union packed {
    struct packed {
      logic [cfg_data_width-1:0] data;
      logic [cfg_addr_width-1:0] addr;
      logic [6:0]                zero;
      logic                      start;
    } cmd;
    struct packed {
      logic [cfg_data_width-1:0] rdata;
      logic [cfg_addr_width-1:0] addr;
      logic [6:0]                zero;
      logic                      done;
    } stat;
  } cfg_word_u;

endpackage

//--- logic/adc5g_apb_regs.sv
// ======================================
// APB register block for the ADC controller
// word 0 is control (reset requests),
// words 1..num_adc are per channel config;
// a busy channel holds pready low
// ======================================
`timescale 1ns/1ps

module adc5g_apb_regs (
  input  logic                                                         OPB_Clk,
  input  logic                                                         rst_n,
  input  logic                                                         psel,
  input  logic                                                         penable,
  input  logic                                                         pwrite,
  input  logic [3:0]                                                   paddr,
  input  logic [adc5g_pkg::bus_width-1:0]                              pwdata,
  input  logic [3:0]                                                   pstrb,
  output logic [adc5g_pkg::bus_width-1:0]                              prdata,
  output logic                                                         pready,
  input  logic [adc5g_pkg::num_adc-1:0]                                done,
  input  logic [adc5g_pkg::num_adc-1:0][adc5g_pkg::cfg_data_width-1:0] read_data,
  output logic [adc5g_pkg::num_adc-1:0]                                start,
  output logic [adc5g_pkg::num_adc-1:0]                                reset_req,
  output logic [adc5g_pkg::num_adc-1:0][adc5g_pkg::cfg_addr_width-1:0] cmd_addr,
  output logic [adc5g_pkg::num_adc-1:0][adc5g_pkg::cfg_data_width-1:0] cmd_data
);
  import adc5g_pkg::*;

  logic [1:0]         word_idx;
  logic               access;
  logic               wr_accept;
  logic               ctrl_hit;
  logic [num_adc-1:0] cfg_hit;
  logic               cfg_busy;
  cfg_word_u          wr_word;
  cfg_word_u          rd_word;

  assign word_idx  = paddr[3:2];
  assign access    = psel & penable;
  assign ctrl_hit  = (int'(word_idx) == reg_ctrl_idx);
  assign wr_word   = pwdata;

  // channel decode and status word
  always_comb begin
    cfg_busy = 1'b0;
    rd_word  = '0;
    for (int n = 0; n < num_adc; n++) begin
      cfg_hit[n] = (int'(word_idx) == reg_cfg_base + n);
      if (cfg_hit[n]) begin
        cfg_busy           = ~done[n];
        rd_word.stat.rdata = read_data[n];
        rd_word.stat.addr  = cmd_addr[n];
        rd_word.stat.done  = done[n];
      end
    end
  end

  // wait states only while the addressed channel is busy
  assign pready    = access & ~cfg_busy;
  assign wr_accept = pready & pwrite;
  assign prdata    = rd_word;  // zero for control and unused words

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      start     <= '0;
      reset_req <= '0;
      cmd_addr  <= '0;
      cmd_data  <= '0;
    end else begin
      start     <= '0;  // single cycle pulses
      reset_req <= '0;
      if (wr_accept && ctrl_hit && pstrb[0]) begin
        reset_req <= pwdata[num_adc-1:0];
      end
      for (int n = 0; n < num_adc; n++) begin
        if (wr_accept && cfg_hit[n]) begin
          if (pstrb[0]) begin
            start[n] <= wr_word.cmd.start;
          end
          if (pstrb[1]) begin
            cmd_addr[n] <= wr_word.cmd.addr;
          end
          if (pstrb[2]) begin
            cmd_data[n][7:0] <= wr_word.cmd.data[7:0];
          end
          if (pstrb[3]) begin
            cmd_data[n][15:8] <= wr_word.cmd.data[15:8];
          end
        end
      end
    end
  end

endmodule

//--- logic/adc3wire_engine.sv
// ======================================
// 3-wire serial port engine for one ADC
// runs a 24 bit write or an 8 bit address
// plus 16 bit read frame per start pulse,
// and stretches reset requests to a pulse
// ======================================
`timescale 1ns/1ps

module adc3wire_engine (
  input  logic                                OPB_Clk,
  input  logic                                rst_n,
  input  logic                                start,
  input  logic                                reset_req,
  input  logic [adc5g_pkg::cfg_addr_width-1:0] cmd_addr,
  input  logic [adc5g_pkg::cfg_data_width-1:0] cmd_data,
  input  logic                                sdout,
  output logic                                done,
  output logic [adc5g_pkg::cfg_data_width-1:0] read_data,
  output logic                                sclk,
  output logic                                sdata,
  output logic                                modepin,
  output logic                                adc_reset
);
  import adc5g_pkg::*;

  logic [state_bits-1:0]     state;
  logic [sclk_div_bits-1:0]  div_cnt;
  logic                      sclk_fall;
  logic                      sclk_prerise;
  logic                      sclk_midhigh;
  logic [frame_bits-1:0]     out_shift;
  logic [cfg_data_width-1:0] in_shift;
  logic [prog_bits-1:0]      bit_cnt;
  logic                      writing;
  logic [rst_cnt_bits-1:0]   rst_cnt;

  // serial clock divider, parked at zero when idle
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (state == st_idle) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign sclk_fall    = (div_cnt == sclk_div_bits'(sclk_fall_cnt));
  assign sclk_prerise = (div_cnt == sclk_div_bits'(sclk_prerise_cnt));
  assign sclk_midhigh = (div_cnt == sclk_div_bits'(sclk_midhigh_cnt));

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      writing   <= 1'b0;
      bit_cnt   <= '0;
      out_shift <= '0;
      read_data <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_clkwait;
            writing   <= cmd_addr[cfg_write_bit];
            out_shift <= {cmd_addr, cmd_data};
          end
        end
        st_clkwait: begin
          if (sclk_fall) begin
            state   <= st_addr;
            bit_cnt <= '0;
          end
        end
        st_addr: begin
          if (sclk_fall) begin
            out_shift <= out_shift << 1;
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == prog_bits'(cfg_addr_width - 1)) begin
              state <= writing ? st_write : st_readwait;
            end
          end
        end
        st_readwait: begin  // one period with sclk low
          if (sclk_fall) begin
            state   <= st_read;
            bit_cnt <= '0;
          end
        end
        st_write: begin
          if (sclk_fall) begin
            out_shift <= out_shift << 1;
            bit_cnt   <= bit_cnt + 1'b1;
          end
          if (sclk_midhigh && bit_cnt == prog_bits'(frame_bits - 1)) begin
            state <= st_almost_done;
          end
        end
        st_read: begin
          if (sclk_prerise) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (sclk_midhigh && bit_cnt == prog_bits'(cfg_data_width)) begin
            state <= st_almost_done;
          end
        end
        st_almost_done: begin
          if (sclk_prerise) begin
            state <= st_finish;
          end
        end
        st_finish: begin
          if (sclk_fall) begin
            state <= st_idle;
            if (!writing) begin
              read_data <= in_shift;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // sample just before the rising edge
  always_ff @(posedge OPB_Clk) begin
    if (state == st_read && sclk_prerise) begin
      in_shift <= {in_shift[cfg_data_width-2:0], sdout};
    end
  end

  // reset pulse stretcher, a new request restarts it
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      rst_cnt <= '0;
    end else if (reset_req) begin
      rst_cnt <= rst_cnt_bits'(rst_cycles);
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign done      = (state == st_idle);
  assign sdata     = out_shift[frame_bits-1];  // msb first
  assign sclk      = div_cnt[sclk_div_bits-1] && state != st_readwait && state != st_finish;
  assign modepin   = !(state == st_addr || state == st_write ||
                       state == st_readwait || state == st_read);
  assign adc_reset = (rst_cnt != '0);

endmodule

//--- logic/adc_pin_stage.sv
// ======================================
// output flops for every ADC pin, so the
// pins stay glitch free and map to IOBs
// ======================================
`timescale 1ns/1ps

module adc_pin_stage (
  input  logic                          OPB_Clk,
  input  logic                          rst_n,
  input  logic [adc5g_pkg::num_adc-1:0] eng_sclk,
  input  logic [adc5g_pkg::num_adc-1:0] eng_sdata,
  input  logic [adc5g_pkg::num_adc-1:0] eng_modepin,
  input  logic [adc5g_pkg::num_adc-1:0] eng_reset,
  output logic [adc5g_pkg::num_adc-1:0] adc_sclk,
  output logic [adc5g_pkg::num_adc-1:0] adc_sdata,
  output logic [adc5g_pkg::num_adc-1:0] adc_modepin,
  output logic [adc5g_pkg::num_adc-1:0] adc_reset
);
  import adc5g_pkg::*;

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      adc_sclk    <= '0;
      adc_sdata   <= '0;
      adc_modepin <= {num_adc{1'b1}};  // serial port deselected
      adc_reset   <= '0;
    end else begin
      adc_sclk    <= eng_sclk;
      adc_sdata   <= eng_sdata;
      adc_modepin <= eng_modepin;
      adc_reset   <= eng_reset;
    end
  end

endmodule

//--- logic/adc5g_ctrl_top.sv
// ======================================
// dual ADC controller top level
// APB register block feeding one serial
// engine per ADC, then the pin flops
// ======================================
`timescale 1ns/1ps

module adc5g_ctrl_top (
  input  logic                            OPB_Clk,
  input  logic                            rst_n,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [3:0]                      paddr,
  input  logic [adc5g_pkg::bus_width-1:0] pwdata,
  input  logic [3:0]                      pstrb,
  output logic [adc5g_pkg::bus_width-1:0] prdata,
  output logic                            pready,
  input  logic [adc5g_pkg::num_adc-1:0]   adc_sdout,
  output logic [adc5g_pkg::num_adc-1:0]   adc_sclk,
  output logic [adc5g_pkg::num_adc-1:0]   adc_sdata,
  output logic [adc5g_pkg::num_adc-1:0]   adc_modepin,
  output logic [adc5g_pkg::num_adc-1:0]   adc_reset
);
  import adc5g_pkg::*;

  logic [num_adc-1:0]                     start;
  logic [num_adc-1:0]                     reset_req;
  logic [num_adc-1:0][cfg_addr_width-1:0] cmd_addr;
  logic [num_adc-1:0][cfg_data_width-1:0] cmd_data;
  logic [num_adc-1:0]                     done;
  logic [num_adc-1:0][cfg_data_width-1:0] read_data;
  logic [num_adc-1:0]                     eng_sclk;
  logic [num_adc-1:0]                     eng_sdata;
  logic [num_adc-1:0]                     eng_modepin;
  logic [num_adc-1:0]                     eng_reset;

  adc5g_apb_regs u_regs (
    .OPB_Clk   (OPB_Clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .prdata    (prdata),
    .pready    (pready),
    .done      (done),
    .read_data (read_data),
    .start     (start),
    .reset_req (reset_req),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data)
  );

  // one serial engine per ADC
  for (genvar n = 0; n < num_adc; n++) begin : g_eng
    adc3wire_engine u_eng (
      .OPB_Clk   (OPB_Clk),
      .rst_n     (rst_n),
      .start     (start[n]),
      .reset_req (reset_req[n]),
      .cmd_addr  (cmd_addr[n]),
      .cmd_data  (cmd_data[n]),
      .sdout     (adc_sdout[n]),
      .done      (done[n]),
      .read_data (read_data[n]),
      .sclk      (eng_sclk[n]),
      .sdata     (eng_sdata[n]),
      .modepin   (eng_modepin[n]),
      .adc_reset (eng_reset[n])
    );
  end

  adc_pin_stage u_pins (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .eng_sclk    (eng_sclk),
    .eng_sdata   (eng_sdata),
    .eng_modepin (eng_modepin),
    .eng_reset   (eng_reset),
    .adc_sclk    (adc_sclk),
    .adc_sdata   (adc_sdata),
    .adc_modepin (adc_modepin),
    .adc_reset   (adc_reset)
  );

endmodule

//--- bench/adc_serial_model.sv
// ======================================
// behavioral ADC serial port for the bench
// shifts in sdata on rising sclk and
// returns rd_value after the address bits
// ======================================
`timescale 1ns/1ps

module adc_serial_model (
  input  logic                                 clk,
  input  logic                                 sclk,
  input  logic                                 sdata,
  input  logic                                 modepin,
  input  logic [adc5g_pkg::cfg_data_width-1:0] rd_value,
  output logic                                 sdout,
  output logic [7:0]                           bit_count,
  output logic [adc5g_pkg::frame_bits-1:0]     frame_word
);
  import adc5g_pkg::*;

  logic sclk_q;
  logic modepin_q;

  initial begin
    sdout      = 1'b0;
    bit_count  = '0;
    frame_word = '0;
    sclk_q     = 1'b0;
    modepin_q  = 1'b1;
  end

  // pins are stable at the falling clock edge
  always @(negedge clk) begin
    if (!modepin && modepin_q) begin  // new frame
      bit_count  <= '0;
      frame_word <= '0;
    end else if (!modepin && sclk && !sclk_q) begin
      frame_word <= {frame_word[frame_bits-2:0], sdata};
      bit_count  <= bit_count + 1'b1;
      if (bit_count >= cfg_addr_width - 1 && bit_count < frame_bits - 1) begin
        sdout <= rd_value[frame_bits - 2 - bit_count];  // msb first
      end
    end
    sclk_q    <= sclk;
    modepin_q <= modepin;
  end

endmodule

//--- bench/tb_adc5g_ctrl.sv
// ======================================
// testbench for the dual ADC controller
// runs the operations listed in the
// vectors file over APB, with one serial
// port model per ADC on the pins
// ======================================
`timescale 1ns/1ps

module tb_adc5g_ctrl;
  import adc5g_pkg::*;

  localparam int num_vec  = 10;
  localparam int vec_cols = 5;  // op, channel, address, data, expected
  localparam int max_wait = 4000;

  logic                      OPB_Clk;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [3:0]                paddr;
  logic [bus_width-1:0]      pwdata;
  logic [3:0]                pstrb;
  logic [bus_width-1:0]      prdata;
  logic                      pready;
  wire  [num_adc-1:0]        adc_sdout;
  logic [num_adc-1:0]        adc_sclk;
  logic [num_adc-1:0]        adc_sdata;
  logic [num_adc-1:0]        adc_modepin;
  logic [num_adc-1:0]        adc_reset;
  logic [cfg_data_width-1:0] model_rdata [num_adc];
  wire  [7:0]                frame_count [num_adc];
  wire  [frame_bits-1:0]     frame_word [num_adc];
  logic [31:0]               vec_mem [num_vec*vec_cols];
  int                        errors;
  int                        checks;
  int                        seed;

  always #20 OPB_Clk = ~OPB_Clk;

  adc5g_ctrl_top UUT (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .prdata      (prdata),
    .pready      (pready),
    .adc_sdout   (adc_sdout),
    .adc_sclk    (adc_sclk),
    .adc_sdata   (adc_sdata),
    .adc_modepin (adc_modepin),
    .adc_reset   (adc_reset)
  );

  for (genvar n = 0; n < num_adc; n++) begin : g_model
    adc_serial_model u_model (
      .clk        (OPB_Clk),
      .sclk       (adc_sclk[n]),
      .sdata      (adc_sdata[n]),
      .modepin    (adc_modepin[n]),
      .rd_value   (model_rdata[n]),
      .sdout      (adc_sdout[n]),
      .bit_count  (frame_count[n]),
      .frame_word (frame_word[n])
    );
  end

  function automatic logic [3:0] cfg_paddr(input int ch);
    return 4'((reg_cfg_base + ch) * 4);
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  // one APB transfer, waits counts the extra access cycles
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata, output int waits);
    @(negedge OPB_Clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(negedge OPB_Clk);
    penable = 1'b1;
    waits   = 0;
    #1;  // let pready settle
    while (!pready && waits < max_wait) begin
      @(negedge OPB_Clk);
      #1;
      waits++;
    end
    if (!pready) begin
      report_failure("pready never rose during an APB access");
    end
    rdata = prdata;
    @(negedge OPB_Clk);  // transfer completed on the rising edge before
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pstrb   = 4'h0;
  endtask

  task automatic check_idle(input int ch, input logic [31:0] exp);
    logic [31:0] rd;
    int          waits;
    apb_xfer(1'b0, cfg_paddr(ch), '0, 4'h0, rd, waits);
    compare("pready_waits", 0, waits);
    compare("prdata", exp, rd);
    compare("adc_reset", 0, adc_reset[ch]);
    compare("adc_modepin", 1, adc_modepin[ch]);
  endtask

  // start a frame, then the status read stalls until done
  task automatic run_frame(input int ch, input logic [7:0] addr, input logic [15:0] data,
                           input logic [31:0] exp);
    logic [31:0] rd;
    int          waits;
    model_rdata[ch] = data;
    apb_xfer(1'b1, cfg_paddr(ch), {data, addr, 8'h01}, 4'hf, rd, waits);
    compare("pready_waits", 0, waits);
    apb_xfer(1'b0, cfg_paddr(ch), '0, 4'h0, rd, waits);
    compare("prdata_done", 1, rd[0]);
    compare("prdata_addr", addr, rd[15:8]);
    compare("frame_count", frame_bits, frame_count[ch]);
    if (addr[cfg_write_bit]) begin
      compare("frame_word", exp, frame_word[ch]);
    end else begin
      compare("frame_addr", addr, frame_word[ch][23:16]);
      compare("prdata_data", exp, rd[31:16]);
    end
  endtask

  task automatic check_backpressure(input int ch, input logic [7:0] addr,
                                    input logic [15:0] data, input logic [31:0] exp);
    logic [31:0] rd;
    int          waits;
    int          other;
    other = (ch + 1) % num_adc;
    model_rdata[ch] = data;
    apb_xfer(1'b1, cfg_paddr(ch), {data, addr, 8'h01}, 4'hf, rd, waits);
    apb_xfer(1'b0, cfg_paddr(other), '0, 4'h0, rd, waits);
    compare("pready_waits_other", 0, waits);
    compare("prdata_done_other", 1, rd[0]);
    apb_xfer(1'b0, cfg_paddr(ch), '0, 4'h0, rd, waits);
    if (waits == 0) begin
      report_failure("read of a busy channel finished without wait states");
    end
    compare("prdata_done", 1, rd[0]);
    compare("prdata_data", exp, rd[31:16]);
  endtask

  task automatic check_reset_pulse(input int ch, input logic [31:0] exp);
    logic [31:0] rd;
    int          waits;
    int          t;
    int          high;
    logic        other_high;
    other_high = 1'b0;
    apb_xfer(1'b1, 4'((reg_ctrl_idx) * 4), 32'(1) << ch, 4'b0001, rd, waits);
    t = 0;
    while (!adc_reset[ch] && t < 64) begin
      @(negedge OPB_Clk);
      t++;
    end
    if (!adc_reset[ch]) begin
      report_failure("reset pulse never started");
    end
    high = 0;
    while (adc_reset[ch] && high < 64) begin
      if (adc_reset[(ch + 1) % num_adc]) begin
        other_high = 1'b1;
      end
      high++;
      @(negedge OPB_Clk);
    end
    compare("adc_reset_cycles", exp, high);
    compare("adc_reset_other", 0, other_high);
  endtask

  // lane 1 only moves the address, lane 0 only starts
  task automatic check_strobes(input int ch, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic [31:0] junk;
    int          waits;
    junk = $random(seed);
    apb_xfer(1'b1, cfg_paddr(ch), {junk[15:0], addr, 8'h01}, 4'b0010, rd, waits);
    apb_xfer(1'b0, cfg_paddr(ch), '0, 4'h0, rd, waits);
    compare("pready_waits", 0, waits);
    compare("prdata_addr", addr, rd[15:8]);
    junk = $random(seed);
    apb_xfer(1'b1, cfg_paddr(ch), {junk[31:8], 8'h01}, 4'b0001, rd, waits);
    apb_xfer(1'b0, cfg_paddr(ch), '0, 4'h0, rd, waits);
    compare("prdata_addr", addr, rd[15:8]);
    compare("frame_word", exp, frame_word[ch]);
  endtask

  initial begin
    int          op;
    int          ch;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    OPB_Clk = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 4'h0;
    pwdata  = '0;
    pstrb   = 4'h0;
    errors  = 0;
    checks  = 0;
    seed    = 11;
    for (int n = 0; n < num_adc; n++) begin
      model_rdata[n] = '0;
    end
    $readmemh("bench/adc5g_vectors.txt", vec_mem);
    repeat (8) @(negedge OPB_Clk);
    rst_n = 1'b1;
    for (int v = 0; v < num_vec; v++) begin
      op     = vec_mem[v*vec_cols];
      ch     = vec_mem[v*vec_cols+1];
      f_addr = vec_mem[v*vec_cols+2];
      f_data = vec_mem[v*vec_cols+3];
      f_exp  = vec_mem[v*vec_cols+4];
      case (op)
        0:       check_idle(ch, f_exp);
        1, 2:    run_frame(ch, f_addr[7:0], f_data[15:0], f_exp);
        3:       check_backpressure(ch, f_addr[7:0], f_data[15:0], f_exp);
        4:       check_reset_pulse(ch, f_exp);
        5:       check_strobes(ch, f_addr[7:0], f_exp);
        default: report_failure("unknown operation code in the vectors file");
      endcase
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/adc5g_vectors.txt
// op chan addr data expected, all hex; op 0 idle read, 1 write frame,
// 2 read frame, 3 busy read, 4 reset pulse, 5 byte strobes
0 0 00 0000 00000001
0 1 00 0000 00000001
1 0 a5 1234 00a51234
1 1 83 beef 0083beef
2 0 21 c3a5 0000c3a5
3 1 42 5a0f 00005a0f
4 1 00 0000 00000010
4 0 00 0000 00000010
5 0 9c 0000 009cc3a5
5 1 f0 0000 00f05a0f

//--- tb.f
logic/adc5g_pkg.sv
logic/adc5g_apb_regs.sv
logic/adc3wire_engine.sv
logic/adc_pin_stage.sv
logic/adc5g_ctrl_top.sv
bench/adc_serial_model.sv
bench/tb_adc5g_ctrl.sv

//--- Bender.yml
package:
  name: adc5g_ctrl

sources:
  - logic/adc5g_pkg.sv
  - logic/adc5g_apb_regs.sv
  - logic/adc3wire_engine.sv
  - logic/adc_pin_stage.sv
  - logic/adc5g_ctrl_top.sv
  - target: simulation
    files:
      - bench/adc_serial_model.sv
      - bench/tb_adc5g_ctrl.sv
